// ==== pce_cfg_pkg.sv ====
// Host status word layout, pad option struct and option decode
package pce_cfg_pkg;

	// ================================================
	// Host status word
	// ================================================

	// Only the controller bits are named, the rest stay opaque
	typedef struct packed {
		logic [19:0] rsvd_hi;    // Bits 31..12
		logic        mouse_en;   // Bit 11
		logic        buttons6;   // Bit 10
		logic        turbotap;   // Bit 9
		logic        joy_swap;   // Bit 8
		logic [7:0]  rsvd_lo;    // Video and system options
	} status_t;

	// ================================================
	// Options seen by the controller port
	// ================================================

	typedef struct packed {
		logic turbotap;   // Five-port tap stepping
		logic buttons6;   // High bank on alternate CLR
		logic mouse_en;   // Port 0 reads as mouse
	} pad_opts_t;

	// Pull the port options out of the status word
	function automatic pad_opts_t decode_opts(input status_t s);
		pad_opts_t o;
		o.turbotap = s.turbotap;
		o.buttons6 = s.buttons6;
		o.mouse_en = s.mouse_en;
		return o;
	endfunction

endpackage

// ==== pce_io_pkg.sv ====
// Host joystick, mouse, pad bus and audio sample types with their widths
package pce_io_pkg;

	localparam int NUM_PADS = 5;    // Host joysticks 0..4
	localparam int PSG_W    = 20;
	localparam int ADPCM_W  = 16;
	localparam int MIX_W    = 22;   // Two bits of headroom over PSG_W
	localparam int DAC_W    = 20;

	// ================================================
	// Controller side
	// ================================================

	// Host joystick word, active high
	typedef struct packed {
		logic [19:0] rsvd;
		logic        btn_vi;    // Bit 11
		logic        btn_v;
		logic        btn_iv;
		logic        btn_iii;   // Bit 8
		logic        run;       // Bit 7
		logic        select;
		logic        btn_ii;
		logic        btn_i;     // Bit 4
		logic        up;        // Bit 3
		logic        down;
		logic        left;
		logic        right;     // Bit 0
	} host_joy_t;

	typedef host_joy_t [NUM_PADS-1:0] host_pads_t;

	typedef struct packed {
		logic [8:0] x;
		logic [8:0] y;
		logic [7:0] flags;    // Bit 0 left button, bit 1 right button
		logic       strobe;   // New movement sample
	} mouse_in_t;

	// Lines driven by the console
	typedef struct packed {
		logic clr;
		logic sel;
	} pad_bus_t;

	typedef logic [3:0]  pad_nibble_t;
	typedef logic [15:0] pad_word_t;
	typedef logic [2:0]  port_idx_t;

	// ================================================
	// Audio side
	// ================================================

	typedef logic signed [PSG_W-1:0]   psg_smp_t;
	typedef logic signed [ADPCM_W-1:0] adpcm_smp_t;
	typedef logic signed [MIX_W-1:0]   mix_t;
	typedef logic [DAC_W-1:0]          dac_word_t;   // Offset binary

	typedef struct packed {
		psg_smp_t   psg_l;
		psg_smp_t   psg_r;
		psg_smp_t   cdda_l;
		psg_smp_t   cdda_r;
		adpcm_smp_t adpcm;    // Mono, fed to both channels
	} audio_in_t;

	typedef struct packed {
		dac_word_t left;
		dac_word_t right;
	} audio_out_t;

endpackage

// ==== pad_port.sv ====
// Controller port with pad mapping, turbo-tap stepping, six-button bank and mouse sequencer
`timescale 1ns/100ps

module pad_port #(
	parameter int MOUSE_TO_BITS = 15
) (
	input  logic                    clk_sys,
	input  logic                    rst_n,
	input  pce_cfg_pkg::pad_opts_t  opts,
	input  pce_io_pkg::host_pads_t  pads,
	input  pce_io_pkg::mouse_in_t   mouse,
	input  pce_io_pkg::pad_bus_t    pad_bus,
	output pce_io_pkg::pad_nibble_t joy_in
);
	import pce_io_pkg::*;

	// Active-low pad word with nibble 0 in the low bits and nibble 3 at 0
	function automatic pad_word_t map_pad(input host_joy_t j);
		map_pad = ~{4'hF,
			j.btn_vi, j.btn_v, j.btn_iv, j.btn_iii,
			j.left, j.down, j.right, j.up,
			j.run, j.select, j.btn_ii, j.btn_i};
	endfunction

	pad_bus_t                 bus_q;       // CLR/SEL one cycle back
	port_idx_t                port_idx;
	logic                     high_bank;   // Selects nibbles 2 and 3
	logic [1:0]               mouse_cnt;
	logic [1:0]               cnt_now;     // Count with the idle timeout applied
	logic [MOUSE_TO_BITS-1:0] idle_cnt;
	logic [7:0]               acc_x;
	logic [7:0]               acc_y;
	logic [7:0]               rd_x;        // Snapshot read by the console
	logic [7:0]               rd_y;
	logic                     clr_rise;
	logic                     sel_rise;
	logic                     idle_done;
	logic [3:0]               move_nib;
	logic [7:0]               mouse_byte;
	pad_word_t                port_word;

	// ================================================
	// Bus edges and idle timer
	// ================================================

	assign clr_rise  = pad_bus.clr & ~bus_q.clr;
	assign sel_rise  = pad_bus.sel & ~bus_q.sel;
	assign idle_done = &idle_cnt;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			bus_q    <= '0;
			idle_cnt <= '0;
		end else begin
			bus_q <= pad_bus;
			if (pad_bus.clr)
				idle_cnt <= '0;
			else if (!idle_done)
				idle_cnt <= idle_cnt + 1'b1;   // Saturates
		end
	end

	// Tap port index and six-button bank
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			port_idx  <= '0;
			high_bank <= 1'b0;
		end else if (pad_bus.clr) begin
			port_idx <= '0;
			if (clr_rise)
				high_bank <= ~high_bank & opts.buttons6;
		end else if (sel_rise && opts.turbotap) begin
			port_idx <= port_idx + 3'd1;   // 7 wraps to 0
		end
	end

	// ================================================
	// Mouse sequencer
	// ================================================

	assign cnt_now = idle_done ? 2'd3 : mouse_cnt;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			mouse_cnt <= 2'd3;
			acc_x     <= '0;
			acc_y     <= '0;
			rd_x      <= '0;
			rd_y      <= '0;
		end else begin
			if (idle_done)
				mouse_cnt <= 2'd3;   // Console stopped reading so the sequence restarts
			if (clr_rise) begin
				mouse_cnt <= cnt_now + 2'd1;
				if (cnt_now == 2'd3) begin
					// Snapshot at the start of a new read cycle
					rd_x  <= acc_x;
					rd_y  <= acc_y;
					acc_x <= '0;
					acc_y <= '0;
				end
			end
			// A fresh host sample wins over the clear
			if (mouse.strobe) begin
				acc_x <= 8'd0 - mouse.x[7:0];   // X axis runs the other way
				acc_y <= mouse.y[7:0];
			end
		end
	end

	always_comb begin
		case (cnt_now)
			2'd0:    move_nib = rd_x[7:4];
			2'd1:    move_nib = rd_x[3:0];
			2'd2:    move_nib = rd_y[7:4];
			default: move_nib = rd_y[3:0];
		endcase
	end

	assign mouse_byte = {move_nib,
		~{pads[0].select, pads[0].run, mouse.flags[0], mouse.flags[1]}};

	// ================================================
	// Word select and nibble latch
	// ================================================

	always_comb begin
		if (port_idx == 3'd0 && opts.mouse_en)
			port_word = {mouse_byte, mouse_byte};
		else if (port_idx < port_idx_t'(NUM_PADS))
			port_word = map_pad(pads[port_idx]);
		else
			port_word = 16'h0FFF;   // Empty tap ports
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n)
			joy_in <= '0;
		else if (pad_bus.clr)
			joy_in <= '0;
		else
			joy_in <= port_word[{high_bank, pad_bus.sel, 2'b00} +: 4];
	end

endmodule

// ==== audio_mix.sv ====
// Three-source stereo mixer with saturation to offset-binary DAC words
`timescale 1ns/100ps

module audio_mix (
	input  logic                   clk_sys,
	input  logic                   rst_n,
	input  pce_io_pkg::audio_in_t  audio_in,
	output pce_io_pkg::audio_out_t audio_out
);
	import pce_io_pkg::*;

	// Sign extend a PSG or CD sample to mix width
	function automatic mix_t widen(input psg_smp_t s);
		widen = {{(MIX_W-PSG_W){s[PSG_W-1]}}, s};
	endfunction

	// Clip when the top three bits disagree, else flip sign for offset binary
	function automatic dac_word_t clamp(input mix_t s);
		logic sgn;
		sgn = s[MIX_W-1];
		if (s[MIX_W-1 -: 3] == 3'b000 || s[MIX_W-1 -: 3] == 3'b111)
			clamp = {~sgn, s[DAC_W-2:0]};
		else
			clamp = {DAC_W{~sgn}};   // FFFFF up, 00000 down
	endfunction

	mix_t adpcm_ext;   // ADPCM times 16
	mix_t sum_l;
	mix_t sum_r;

	assign adpcm_ext = {{(MIX_W-ADPCM_W-4){audio_in.adpcm[ADPCM_W-1]}},
		audio_in.adpcm, 4'b0000};

	// ================================================
	// Sum register
	// ================================================

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			sum_l <= '0;
			sum_r <= '0;
		end else begin
			sum_l <= widen(audio_in.psg_l) + widen(audio_in.cdda_l) + adpcm_ext;
			sum_r <= widen(audio_in.psg_r) + widen(audio_in.cdda_r) + adpcm_ext;
		end
	end

	assign audio_out = '{left: clamp(sum_l), right: clamp(sum_r)};

endmodule

// ==== pce_io_top.sv ====
// Top level with option decode, joystick swap, controller port and audio mixer
`timescale 1ns/100ps

module pce_io_top #(
	parameter int MOUSE_TO_BITS = 15
) (
	input  logic                    clk_sys,
	input  logic                    rst_n,
	input  pce_cfg_pkg::status_t    status,
	input  pce_io_pkg::host_pads_t  joys,
	input  pce_io_pkg::mouse_in_t   mouse,
	input  pce_io_pkg::pad_bus_t    pad_bus,
	input  pce_io_pkg::audio_in_t   audio_in,
	output pce_io_pkg::pad_nibble_t joy_in,
	output pce_io_pkg::audio_out_t  audio_out
);
	import pce_cfg_pkg::*;
	import pce_io_pkg::*;

	pad_opts_t  opts;
	host_pads_t pads;   // Joysticks after swap

	assign opts = decode_opts(status);

	// ================================================
	// Joystick swap, first two pads only
	// ================================================

	always_comb begin
		pads = joys;
		if (status.joy_swap) begin
			pads[0] = joys[1];
			pads[1] = joys[0];
		end
	end

	pad_port #(
		.MOUSE_TO_BITS(MOUSE_TO_BITS)
	) u_pad_port (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.opts    (opts),
		.pads    (pads),
		.mouse   (mouse),
		.pad_bus (pad_bus),
		.joy_in  (joy_in)
	);

	audio_mix u_audio_mix (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.audio_in  (audio_in),
		.audio_out (audio_out)
	);

endmodule

// ==== tb_pce_io_checker.sv ====
// Checker that samples DUT outputs at driver strobes and counts mismatches
`timescale 1ns/100ps

module tb_pce_io_checker (
	input  logic                    clk_sys,
	input  logic [1:0]              check,       // Bit 0 joy_in, bit 1 audio_out
	input  pce_io_pkg::pad_nibble_t exp_joy,
	input  pce_io_pkg::audio_out_t  exp_audio,
	input  pce_io_pkg::pad_nibble_t joy_in,
	input  pce_io_pkg::audio_out_t  audio_out,
	output int                      checks,
	output int                      errs
);
	import pce_io_pkg::*;

	initial begin
		checks = 0;
		errs   = 0;
	end

	// Falling edge, registered outputs have settled by then
	always @(negedge clk_sys) begin
		if (check != 2'b00)
			checks++;
		if (check[0] && joy_in !== exp_joy) begin
			errs++;
			$display("FAILED at %0t: joy_in %h, expected %h", $time, joy_in, exp_joy);
		end
		if (check[1] && audio_out !== exp_audio) begin
			errs++;
			$display("FAILED at %0t: audio_out %h/%h, expected %h/%h", $time,
				audio_out.left, audio_out.right, exp_audio.left, exp_audio.right);
		end
	end

endmodule

// ==== tb_pce_io.sv ====
// Testbench top with clock, reset, DUT, case file reader, stimulus driver and timeout
`timescale 1ns/100ps

module tb_pce_io;
	import pce_cfg_pkg::*;
	import pce_io_pkg::*;

	// One case line, type letter and seven hex fields
	typedef struct packed {
		logic [7:0]       kind;
		logic [6:0][31:0] f;
	} case_t;

	logic        clk_sys;
	logic        rst_n;
	status_t     status;
	host_pads_t  joys;
	mouse_in_t   mouse;
	pad_bus_t    pad_bus;
	audio_in_t   audio_in;
	pad_nibble_t joy_in;
	audio_out_t  audio_out;
	logic [1:0]  check;       // Strobe to the checker, one bit per output
	pad_nibble_t exp_joy;
	audio_out_t  exp_audio;
	int          checks;
	int          errs;
	int          file_errs = 0;
	int          limit = 0;   // Set once the case count is known
	int          cycles = 0;
	case_t       cases[$];

	pce_io_top #(.MOUSE_TO_BITS(6)) u_pce_io_top (
		.clk_sys(clk_sys), .rst_n(rst_n), .status(status), .joys(joys), .mouse(mouse),
		.pad_bus(pad_bus), .audio_in(audio_in), .joy_in(joy_in), .audio_out(audio_out)
	);

	tb_pce_io_checker u_checker (
		.clk_sys(clk_sys), .check(check), .exp_joy(exp_joy), .exp_audio(exp_audio),
		.joy_in(joy_in), .audio_out(audio_out), .checks(checks), .errs(errs)
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// Wait out the DUT latency, then strobe the checker for one cycle
	task automatic request_check(input logic [1:0] which, input logic [31:0] ej,
		input logic [31:0] el, input logic [31:0] er);
		repeat (2) @(posedge clk_sys);
		#1;
		exp_joy   = ej[3:0];
		exp_audio = '{left: el[19:0], right: er[19:0]};
		check     = which;
		@(posedge clk_sys);
		#1 check = 2'b00;
	endtask

	task automatic apply_case(input case_t c);
		@(posedge clk_sys);
		#1;
		case (c.kind)
			"C": request_check(2'b11, c.f[0], c.f[1], c.f[2]);
			"S": status = c.f[0];
			"J": joys[c.f[0]] = c.f[1];
			"W": repeat (c.f[0]) @(posedge clk_sys);
			"M": begin
				mouse = '{x: c.f[0][8:0], y: c.f[1][8:0], flags: c.f[2][7:0], strobe: 1'b1};
				@(posedge clk_sys);
				#1 mouse.strobe = 1'b0;
			end
			"P": begin
				pad_bus = c.f[0][1:0];   // Pre phase {clr, sel}
				repeat (2) @(posedge clk_sys);
				#1 pad_bus = c.f[1][1:0];
				request_check(2'b01, c.f[2], 32'd0, 32'd0);
			end
			"A": begin
				audio_in = '{psg_l: c.f[0][19:0], psg_r: c.f[1][19:0], cdda_l: c.f[2][19:0],
					cdda_r: c.f[3][19:0], adpcm: c.f[4][15:0]};
				request_check(2'b10, 32'd0, c.f[5], c.f[6]);
			end
			default: begin
				file_errs++;
				$display("Unknown case type '%c' in pce_io_cases.txt", c.kind);
			end
		endcase
	endtask

	initial begin
		int               fd;
		int               n;
		logic [7:0]       tok;
		logic [31:0]      v [0:6];
		logic [8*128-1:0] rest;
		case_t            c;
		rst_n     = 1'b0;
		status    = '0;
		joys      = '0;
		mouse     = '0;
		pad_bus   = '{clr: 1'b1, sel: 1'b0};   // Port held cleared
		audio_in  = '0;
		check     = 2'b00;
		exp_joy   = '0;
		exp_audio = '0;
		fd = $fopen("pce_io_cases.txt", "r");
		if (fd == 0) begin
			file_errs++;
			$display("Could not open pce_io_cases.txt");
		end else begin
			while ($fscanf(fd, "%s", tok) == 1) begin
				if (tok == "#") begin
					n = $fgets(rest, fd);
				end else begin
					n = $fscanf(fd, "%h %h %h %h %h %h %h", v[0], v[1], v[2], v[3], v[4],
						v[5], v[6]);
					if (n != 7) begin
						file_errs++;
						$display("Case line of type '%c' has too few fields", tok);
					end
					c.kind = tok;
					c.f    = {v[6], v[5], v[4], v[3], v[2], v[1], v[0]};
					cases.push_back(c);
				end
			end
			$fclose(fd);
		end
		limit = cases.size() * 80 + 200;
		repeat (3) @(posedge clk_sys);
		#1 rst_n = 1'b1;
		foreach (cases[i])
			apply_case(cases[i]);
		repeat (2) @(posedge clk_sys);
		$display("Checks %0d, errors %0d, case file errors %0d", checks, errs, file_errs);
		if (errs == 0 && file_errs == 0 && checks > 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	// Watchdog
	initial begin
		wait (limit > 0);
		while (cycles < limit) begin
			@(posedge clk_sys);
			cycles++;
		end
		$display("Timeout reached after %0d cycles, run stopped", cycles);
		$display("Checks failed");
		$finish;
	end

endmodule

// ==== pce_io_cases.txt ====
# type then seven hex fields; C: joy left right, S: status, J: pad word, W: cycles
# M: x y flags, P: pre post joy with bus {clr,sel}, A: psg_l psg_r cdda_l cdda_r adpcm l r
C 0 80000 80000 0 0 0 0
J 0 a31 0 0 0 0 0
J 1 5c8 0 0 0 0 0
J 2 52 0 0 0 0 0
J 3 f4 0 0 0 0 0
J 4 9 0 0 0 0 0
P 2 0 c 0 0 0 0
P 0 1 d 0 0 0 0
S 100 0 0 0 0 0 0
P 2 0 3 0 0 0 0
P 0 1 e 0 0 0 0
S 200 0 0 0 0 0 0
P 2 0 c 0 0 0 0
P 0 1 e 0 0 0 0
P 0 1 7 0 0 0 0
P 0 1 b 0 0 0 0
P 0 1 c 0 0 0 0
P 0 1 f 0 0 0 0
P 0 1 f 0 0 0 0
P 0 1 f 0 0 0 0
P 0 1 d 0 0 0 0
S 400 0 0 0 0 0 0
P 2 0 5 0 0 0 0
P 0 1 0 0 0 0 0
P 2 0 c 0 0 0 0
S 500 0 0 0 0 0 0
P 2 0 a 0 0 0 0
S 800 0 0 0 0 0 0
W 48 0 0 0 0 0 0
M 13 34 1 0 0 0 0
P 2 1 e 0 0 0 0
P 2 1 d 0 0 0 0
P 2 1 3 0 0 0 0
P 2 1 4 0 0 0 0
P 0 0 d 0 0 0 0
M 21 45 1 0 0 0 0
P 2 1 d 0 0 0 0
M 50 67 1 0 0 0 0
W 48 0 0 0 0 0 0
P 2 1 b 0 0 0 0
A 1000 fffff 2000 0 10 83100 800ff
A 7ffff 40000 7ffff 3ffff 1 fffff fffff
A 80000 c0000 fffff c0000 0 0 0
A 10 0 0 0 7fff fffff ffff0

// ==== tb.f ====
pce_cfg_pkg.sv
pce_io_pkg.sv
pad_port.sv
audio_mix.sv
pce_io_top.sv
tb_pce_io_checker.sv
tb_pce_io.sv
